// ==== accel_pkg.sv ====
// accel_pkg: shared widths, data types, register map and sequencer states of the accelerator
package accel_pkg;

  // data path widths
  localparam int ELEM_W  = 8;
  localparam int ACC_W   = 3 * ELEM_W;
  localparam int PADDR_W = 12;
  localparam int PDATA_W = 32;

  // byte offset bits inside one register or buffer region
  localparam int REGION_W = 8;

  typedef logic [ELEM_W-1:0]  elem_t;
  typedef logic [ACC_W-1:0]   acc_t;
  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [PDATA_W-1:0] pdata_t;

  // register map
  localparam paddr_t CTRL_ADDR   = paddr_t'('h000);
  localparam paddr_t STATUS_ADDR = paddr_t'('h004);
  localparam paddr_t A_BASE      = paddr_t'('h100);
  localparam paddr_t B_BASE      = paddr_t'('h200);
  localparam paddr_t C_BASE      = paddr_t'('h300);

  // CTRL fields
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_IRQ_EN_BIT = 1;

  // STATUS fields
  localparam int STAT_BUSY_BIT = 0;
  localparam int STAT_DONE_BIT = 1;

  // run sequencer of the data feed unit
  typedef enum logic [1:0] {
    IDLE,
    FEED,
    CAPTURE
  } dfu_state_t;

endpackage

// ==== reg_bus_if.sv ====
// reg_bus_if: single-cycle register strobes from the APB target with a registered response
interface reg_bus_if import accel_pkg::*; ();

  // request side, strobes last one cycle
  logic   wr;
  logic   rd;
  paddr_t addr;
  pdata_t wdata;

  // response, valid one cycle after a strobe
  pdata_t rdata;
  logic   err;

  modport master (
    output wr,
    output rd,
    output addr,
    output wdata,
    input  rdata,
    input  err
  );

  modport slave (
    input  wr,
    input  rd,
    input  addr,
    input  wdata,
    output rdata,
    output err
  );

endinterface

// ==== buf_ctrl_if.sv ====
// buf_ctrl_if: buffer writes, result reads and run control between config and data feed units
interface buf_ctrl_if import accel_pkg::*; #(
  parameter int ARRAY_N = 4
) ();

  localparam int IDX_W = $clog2(ARRAY_N * ARRAY_N);

  // operand buffer write, buf_sel low picks A
  logic             buf_wr;
  logic             buf_sel;
  logic [IDX_W-1:0] buf_idx;
  elem_t            buf_wdata;

  // result read port
  logic [IDX_W-1:0] rd_idx;
  acc_t             c_rdata;

  // run control
  logic start;
  logic busy;
  logic done_pulse;

  modport ctrl (
    output buf_wr, buf_sel, buf_idx, buf_wdata, rd_idx, start,
    input  c_rdata, busy, done_pulse
  );

  modport dfu (
    input  buf_wr, buf_sel, buf_idx, buf_wdata, rd_idx, start,
    output c_rdata, busy, done_pulse
  );

endinterface

// ==== array_if.sv ====
// array_if: skewed operand streams into the systolic array and accumulators out of it
interface array_if import accel_pkg::*; #(
  parameter int ARRAY_N = 4
) ();

  // one operand per row of A and per column of B
  elem_t              a_row [ARRAY_N];
  logic [ARRAY_N-1:0] a_vld;
  elem_t              b_col [ARRAY_N];
  logic [ARRAY_N-1:0] b_vld;

  // clears every accumulator before a run
  logic acc_clr;

  // accumulator of cell (i,j)
  acc_t c_mat [ARRAY_N][ARRAY_N];

  modport feeder (
    output a_row, a_vld, b_col, b_vld, acc_clr,
    input  c_mat
  );

  modport array (
    input  a_row, a_vld, b_col, b_vld, acc_clr,
    output c_mat
  );

endinterface

// ==== processing_element.sv ====
// processing_element: multiply-accumulate cell that forwards its operands to the next cells
module processing_element import accel_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  clr,
  input  elem_t a_in,
  input  elem_t b_in,
  input  logic  a_vld_in,
  input  logic  b_vld_in,
  output elem_t a_out,
  output elem_t b_out,
  output logic  a_vld_out,
  output logic  b_vld_out,
  output acc_t  acc
);

  logic [2*ELEM_W-1:0] prod;

  assign prod = a_in * b_in;

  // clear has priority over accumulation
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc       <= '0;
      a_vld_out <= 1'b0;
      b_vld_out <= 1'b0;
    end else begin
      a_vld_out <= a_vld_in;
      b_vld_out <= b_vld_in;
      if (clr) begin
        acc <= '0;
      end else if (a_vld_in && b_vld_in) begin
        acc <= acc + acc_t'(prod);
      end
    end
  end

  // operand pass-through
  always_ff @(posedge clk) begin
    a_out <= a_in;
    b_out <= b_in;
  end

endmodule

// ==== systolic_array.sv ====
// systolic_array: ARRAY_N by ARRAY_N grid of MAC cells, A flows right and B flows down
module systolic_array import accel_pkg::*; #(
  parameter int ARRAY_N = 4
) (
  input logic clk,
  input logic arst_n,
  array_if.array arr
);

  // forwarded operands leaving each cell
  elem_t a_fwd  [ARRAY_N][ARRAY_N];
  elem_t b_fwd  [ARRAY_N][ARRAY_N];
  logic  a_vfwd [ARRAY_N][ARRAY_N];
  logic  b_vfwd [ARRAY_N][ARRAY_N];

  for (genvar i = 0; i < ARRAY_N; i++) begin : g_row
    for (genvar j = 0; j < ARRAY_N; j++) begin : g_col
      elem_t a_src;
      elem_t b_src;
      logic  a_vsrc;
      logic  b_vsrc;

      // left column takes A from the feeder
      if (j == 0) begin : g_a_edge
        assign a_src  = arr.a_row[i];
        assign a_vsrc = arr.a_vld[i];
      end else begin : g_a_inner
        assign a_src  = a_fwd[i][j-1];
        assign a_vsrc = a_vfwd[i][j-1];
      end

      // top row takes B from the feeder
      if (i == 0) begin : g_b_edge
        assign b_src  = arr.b_col[j];
        assign b_vsrc = arr.b_vld[j];
      end else begin : g_b_inner
        assign b_src  = b_fwd[i-1][j];
        assign b_vsrc = b_vfwd[i-1][j];
      end

      processing_element u_pe (
        .clk       (clk),
        .arst_n    (arst_n),
        .clr       (arr.acc_clr),
        .a_in      (a_src),
        .b_in      (b_src),
        .a_vld_in  (a_vsrc),
        .b_vld_in  (b_vsrc),
        .a_out     (a_fwd[i][j]),
        .b_out     (b_fwd[i][j]),
        .a_vld_out (a_vfwd[i][j]),
        .b_vld_out (b_vfwd[i][j]),
        .acc       (arr.c_mat[i][j])
      );
    end
  end

endmodule

// ==== apb_target.sv ====
// apb_target: APB protocol engine issuing one register strobe per transfer with one wait state
module apb_target import accel_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   psel,
  input  logic   penable,
  input  logic   pwrite,
  input  paddr_t paddr,
  input  pdata_t pwdata,
  output pdata_t prdata,
  output logic   pready,
  output logic   pslverr,
  reg_bus_if.master rb
);

  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } apb_state_t;

  apb_state_t state;
  apb_state_t state_nxt;
  logic       xfer;

  // first access cycle of a transfer
  assign xfer = psel && penable && (state == ST_IDLE);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (xfer) begin
          state_nxt = ST_RESP;
        end
      end
      // transfer completes here, master drops penable next
      ST_RESP: begin
        state_nxt = ST_IDLE;
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // strobes toward the config unit
  assign rb.wr    = xfer && pwrite;
  assign rb.rd    = xfer && !pwrite;
  assign rb.addr  = paddr;
  assign rb.wdata = pwdata;

  // response arrives from the config unit registers in the wait-state cycle
  assign pready  = (state == ST_RESP);
  assign prdata  = pready ? rb.rdata : '0;
  assign pslverr = pready && rb.err;

endmodule

// ==== config_unit.sv ====
// config_unit: control and status registers, address decode and done interrupt
module config_unit import accel_pkg::*; #(
  parameter int ARRAY_N = 4
) (
  input  logic clk,
  input  logic arst_n,
  output logic interrupt,
  reg_bus_if.slave rb,
  buf_ctrl_if.ctrl bc
);

  localparam int IDX_W  = $clog2(ARRAY_N * ARRAY_N);
  localparam int RSEL_W = PADDR_W - REGION_W;

  logic [RSEL_W-1:0]   rsel;
  logic [REGION_W-3:0] woff;
  logic   in_buf;
  logic   hit_ctrl;
  logic   hit_status;
  logic   hit_a;
  logic   hit_b;
  logic   hit_c;
  logic   hit_any;
  logic   ro_bits;
  logic   wr_err;
  logic   rd_err;
  logic   irq_en;
  logic   done;
  pdata_t rdata_nxt;

  assign rsel = rb.addr[PADDR_W-1:REGION_W];
  assign woff = rb.addr[REGION_W-1:2];

  // aligned word within the first ARRAY_N*ARRAY_N words of a region
  assign in_buf = (rb.addr[1:0] == 2'b00) && (woff < ARRAY_N * ARRAY_N);

  assign hit_ctrl   = (rb.addr == CTRL_ADDR);
  assign hit_status = (rb.addr == STATUS_ADDR);
  assign hit_a      = in_buf && (rsel == A_BASE[PADDR_W-1:REGION_W]);
  assign hit_b      = in_buf && (rsel == B_BASE[PADDR_W-1:REGION_W]);
  assign hit_c      = in_buf && (rsel == C_BASE[PADDR_W-1:REGION_W]);
  assign hit_any    = hit_ctrl || hit_status || hit_a || hit_b || hit_c;

  // only the done bit of STATUS takes a write
  assign ro_bits = |(rb.wdata & ~(pdata_t'(1) << STAT_DONE_BIT));

  assign wr_err = !hit_any || hit_c || (hit_status && ro_bits) ||
                  ((hit_a || hit_b) && bc.busy);
  assign rd_err = !hit_any;

  // operand writes are held off while a run reads the buffers
  assign bc.buf_wr    = rb.wr && (hit_a || hit_b) && !bc.busy;
  assign bc.buf_sel   = hit_b;
  assign bc.buf_idx   = woff[IDX_W-1:0];
  assign bc.buf_wdata = rb.wdata[ELEM_W-1:0];
  assign bc.rd_idx    = woff[IDX_W-1:0];
  assign bc.start     = rb.wr && hit_ctrl && rb.wdata[CTRL_START_BIT] && !bc.busy;

  // read mux, start bit always reads 0
  always_comb begin
    rdata_nxt = '0;
    if (hit_ctrl) begin
      rdata_nxt[CTRL_IRQ_EN_BIT] = irq_en;
    end else if (hit_status) begin
      rdata_nxt[STAT_BUSY_BIT] = bc.busy;
      rdata_nxt[STAT_DONE_BIT] = done;
    end else if (hit_c) begin
      rdata_nxt = pdata_t'(bc.c_rdata);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      irq_en   <= 1'b0;
      done     <= 1'b0;
      rb.rdata <= '0;
      rb.err   <= 1'b0;
    end else begin
      rb.rdata <= rb.rd ? rdata_nxt : '0;
      rb.err   <= (rb.wr && wr_err) || (rb.rd && rd_err);
      if (rb.wr && hit_ctrl) begin
        irq_en <= rb.wdata[CTRL_IRQ_EN_BIT];
      end
      // a finishing run wins over a clear in the same cycle
      if (bc.done_pulse) begin
        done <= 1'b1;
      end else if (rb.wr && hit_status && !ro_bits && rb.wdata[STAT_DONE_BIT]) begin
        done <= 1'b0;
      end
    end
  end

  assign interrupt = done && irq_en;

endmodule

// ==== data_feed_unit.sv ====
// data_feed_unit: operand and result buffers, run sequencer and skewed feed into the array
module data_feed_unit import accel_pkg::*; #(
  parameter int ARRAY_N = 4
) (
  input logic clk,
  input logic arst_n,
  buf_ctrl_if.dfu bc,
  array_if.feeder arr
);

  localparam int CELLS    = ARRAY_N * ARRAY_N;
  localparam int FEED_LEN = 3 * ARRAY_N - 2;
  localparam int STEP_W   = $clog2(FEED_LEN);

  elem_t a_buf [CELLS];
  elem_t b_buf [CELLS];
  acc_t  c_buf [CELLS];

  dfu_state_t        state;
  logic [STEP_W-1:0] step;

  // buffers, written by the host and by result capture
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int n = 0; n < CELLS; n++) begin
        a_buf[n] <= '0;
        b_buf[n] <= '0;
        c_buf[n] <= '0;
      end
    end else begin
      if (bc.buf_wr && !bc.buf_sel) begin
        a_buf[bc.buf_idx] <= bc.buf_wdata;
      end
      if (bc.buf_wr && bc.buf_sel) begin
        b_buf[bc.buf_idx] <= bc.buf_wdata;
      end
      if (state == CAPTURE) begin
        for (int i = 0; i < ARRAY_N; i++) begin
          for (int j = 0; j < ARRAY_N; j++) begin
            c_buf[i * ARRAY_N + j] <= arr.c_mat[i][j];
          end
        end
      end
    end
  end

  // run sequencer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (bc.start) begin
            state <= FEED;
            step  <= '0;
          end
        end
        FEED: begin
          if (step == STEP_W'(FEED_LEN - 1)) begin
            state <= CAPTURE;
          end else begin
            step <= step + 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // row i gets A[i][t-i], column j gets B[t-j][j]
  always_comb begin
    int   k;
    logic v;
    for (int i = 0; i < ARRAY_N; i++) begin
      k = int'(step) - i;
      v = (state == FEED) && (k >= 0) && (k < ARRAY_N);
      arr.a_vld[i] = v;
      arr.a_row[i] = v ? a_buf[i * ARRAY_N + k] : '0;
    end
    for (int j = 0; j < ARRAY_N; j++) begin
      k = int'(step) - j;
      v = (state == FEED) && (k >= 0) && (k < ARRAY_N);
      arr.b_vld[j] = v;
      arr.b_col[j] = v ? b_buf[k * ARRAY_N + j] : '0;
    end
  end

  assign arr.acc_clr   = bc.start && (state == IDLE);
  assign bc.busy       = (state != IDLE);
  assign bc.done_pulse = (state == CAPTURE);
  assign bc.c_rdata    = c_buf[bc.rd_idx];

endmodule

// ==== accel_top.sv ====
// accel_top: APB-configured matrix multiply accelerator with interrupt and busy outputs
module accel_top import accel_pkg::*; #(
  parameter int ARRAY_N = 4
) (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   psel,
  input  logic   penable,
  input  logic   pwrite,
  input  paddr_t paddr,
  input  pdata_t pwdata,
  output pdata_t prdata,
  output logic   pready,
  output logic   pslverr,
  output logic   interrupt,
  output logic   busy
);

  reg_bus_if rb ();
  buf_ctrl_if #(.ARRAY_N(ARRAY_N)) bc ();
  array_if #(.ARRAY_N(ARRAY_N)) arr ();

  apb_target u_apb_target (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rb      (rb)
  );

  config_unit #(.ARRAY_N(ARRAY_N)) u_config_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .interrupt (interrupt),
    .rb        (rb),
    .bc        (bc)
  );

  data_feed_unit #(.ARRAY_N(ARRAY_N)) u_data_feed_unit (
    .clk    (clk),
    .arst_n (arst_n),
    .bc     (bc),
    .arr    (arr)
  );

  systolic_array #(.ARRAY_N(ARRAY_N)) u_systolic_array (
    .clk    (clk),
    .arst_n (arst_n),
    .arr    (arr)
  );

  assign busy = bc.busy;

endmodule

// ==== tb_accel.sv ====
// tb_accel: directed testbench running matrix products over APB against a reference model
module tb_accel import accel_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N       = 4;
  localparam int TIMEOUT = 100;

  logic   clk;
  logic   arst_n;
  logic   psel;
  logic   penable;
  logic   pwrite;
  paddr_t paddr;
  pdata_t pwdata;
  pdata_t prdata;
  logic   pready;
  logic   pslverr;
  logic   interrupt;
  logic   busy;

  int    errors;
  elem_t a_mat [N*N];
  elem_t b_mat [N*N];

  accel_top #(.ARRAY_N(N)) dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .interrupt (interrupt),
    .busy      (busy)
  );

  always #20 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  function automatic paddr_t word_addr(input paddr_t base, input int idx);
    return paddr_t'(base + 4 * idx);
  endfunction

  // setup phase followed by access phase until pready, sampled mid-cycle
  task automatic apb_access(input logic write, input paddr_t addr, input pdata_t data,
                            output pdata_t rdata, output logic err);
    int cnt;
    cnt = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1;
    @(negedge clk);
    while (!pready && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      $display("APB transfer to 0x%03h timed out waiting for pready", addr);
      errors++;
    end else begin
      // exactly one wait state per transfer
      check("APB wait states", cnt, 1);
    end
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input paddr_t addr, input pdata_t data, output logic err);
    pdata_t unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input paddr_t addr, output pdata_t data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // unsigned C[i][j] as the sum over k of A[i][k] * B[k][j]
  function automatic logic [31:0] model_c(input int i, input int j);
    logic [31:0] sum;
    sum = '0;
    for (int k = 0; k < N; k++) begin
      sum = sum + 32'(a_mat[i*N+k]) * 32'(b_mat[k*N+j]);
    end
    return sum;
  endfunction

  task automatic randomize_operands();
    for (int n = 0; n < N * N; n++) begin
      a_mat[n] = elem_t'($urandom);
      b_mat[n] = elem_t'($urandom);
    end
  endtask

  task automatic load_operands();
    logic err;
    for (int n = 0; n < N * N; n++) begin
      apb_write(word_addr(A_BASE, n), pdata_t'(a_mat[n]), err);
      check("pslverr A write", err, 0);
      apb_write(word_addr(B_BASE, n), pdata_t'(b_mat[n]), err);
      check("pslverr B write", err, 0);
    end
  endtask

  // clear a stale done before writing start with the chosen irq_en
  task automatic start_run(input logic irq_en);
    logic err;
    apb_write(STATUS_ADDR, 32'h2, err);
    check("pslverr STATUS clear", err, 0);
    apb_write(CTRL_ADDR, {30'b0, irq_en, 1'b1}, err);
    check("pslverr CTRL start", err, 0);
  endtask

  task automatic wait_done();
    pdata_t st;
    logic   err;
    int     polls;
    polls = 0;
    apb_read(STATUS_ADDR, st, err);
    while (!st[STAT_DONE_BIT] && polls < TIMEOUT) begin
      apb_read(STATUS_ADDR, st, err);
      polls++;
    end
    if (!st[STAT_DONE_BIT]) begin
      $display("run did not finish, STATUS done still clear after %0d polls", polls);
      errors++;
    end
  endtask

  task automatic check_result();
    pdata_t data;
    logic   err;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        apb_read(word_addr(C_BASE, i * N + j), data, err);
        check("pslverr C read", err, 0);
        check($sformatf("C[%0d][%0d]", i, j), data, model_c(i, j));
      end
    end
  endtask

  task automatic test_reset();
    pdata_t data;
    logic   err;
    check("pready idle", pready, 0);
    check("pslverr idle", pslverr, 0);
    apb_read(STATUS_ADDR, data, err);
    check("STATUS", data, 0);
    check("pslverr STATUS read", err, 0);
    apb_read(CTRL_ADDR, data, err);
    check("CTRL", data, 0);
    check("interrupt", interrupt, 0);
    check("busy", busy, 0);
    for (int n = 0; n < N * N; n++) begin
      apb_read(word_addr(C_BASE, n), data, err);
      check($sformatf("C word %0d", n), data, 0);
    end
  endtask

  task automatic test_registers();
    pdata_t data;
    logic   err;
    apb_write(CTRL_ADDR, 32'h2, err);
    apb_read(CTRL_ADDR, data, err);
    check("CTRL irq_en", data, 32'h2);
    apb_write(CTRL_ADDR, 32'h0, err);
    apb_read(CTRL_ADDR, data, err);
    check("CTRL cleared", data, 0);
    apb_read(paddr_t'('h008), data, err);
    check("pslverr unmapped read", err, 1);
    // one word past the end of A
    apb_read(word_addr(A_BASE, N * N), data, err);
    check("pslverr A range", err, 1);
    apb_write(C_BASE, 32'h5, err);
    check("pslverr C write", err, 1);
    apb_write(STATUS_ADDR, 32'h1, err);
    check("pslverr STATUS busy write", err, 1);
  endtask

  task automatic test_multiply();
    pdata_t data;
    logic   err;
    randomize_operands();
    load_operands();
    start_run(1'b0);
    check("busy after start", busy, 1);
    apb_read(CTRL_ADDR, data, err);
    check("CTRL start reads 0", data, 0);
    wait_done();
    apb_read(STATUS_ADDR, data, err);
    check("STATUS after run", data, 32'h2);
    check("busy after run", busy, 0);
    check_result();
  endtask

  task automatic test_interrupt();
    pdata_t data;
    logic   err;
    start_run(1'b1);
    wait_done();
    check("interrupt after done", interrupt, 1);
    apb_write(STATUS_ADDR, 32'h2, err);
    check("interrupt after clear", interrupt, 0);
    start_run(1'b0);
    wait_done();
    apb_read(STATUS_ADDR, data, err);
    check("STATUS irq_en clear", data, 32'h2);
    check("interrupt masked", interrupt, 0);
  endtask

  task automatic test_busy_protect();
    pdata_t data;
    logic   err;
    randomize_operands();
    load_operands();
    start_run(1'b0);
    // a value the A buffer does not hold
    apb_write(A_BASE, pdata_t'(a_mat[0] ^ elem_t'('1)), err);
    check("pslverr A write while busy", err, 1);
    // second start lands mid-run
    apb_write(CTRL_ADDR, 32'h1, err);
    check("pslverr second start", err, 0);
    check("busy during run", busy, 1);
    wait_done();
    apb_read(STATUS_ADDR, data, err);
    check("STATUS after protected run", data, 32'h2);
    check_result();
  endtask

  task automatic test_back_to_back();
    pdata_t data;
    logic   err;
    for (int n = 0; n < N * N; n++) begin
      b_mat[n] = (n / N == n % N) ? elem_t'(1) : elem_t'(0);
    end
    load_operands();
    start_run(1'b0);
    wait_done();
    // identity B gives back A
    for (int n = 0; n < N * N; n++) begin
      apb_read(word_addr(C_BASE, n), data, err);
      check($sformatf("C word %0d vs A", n), data, pdata_t'(a_mat[n]));
    end
  endtask

  initial begin
    errors = 0;
    void'($urandom(32'hfc3a));
    clk     = 1'b0;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;
    next_cycle();
    test_reset();
    test_registers();
    test_multiply();
    test_interrupt();
    test_busy_protect();
    test_back_to_back();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== files.f ====
accel_pkg.sv
reg_bus_if.sv
buf_ctrl_if.sv
array_if.sv
processing_element.sv
systolic_array.sv
apb_target.sv
config_unit.sv
data_feed_unit.sv
accel_top.sv
tb_accel.sv
